// File: logic/rvCore_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

`define RV_XLEN 64
`define RV_INSN_W 32
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

`define RV_STACK_TOP 64'h0000_0000_0000_3ff0 // x2 after reset

// credits the memory may hand out ahead of requests
`define RV_MEM_CREDITS 2

`endif

// File: logic/rvPkg.sv
`include "rvCore_settings.svh"

package rvPkg;

	typedef logic [`RV_XLEN-1:0] xlen_t;
	typedef logic [`RV_INSN_W-1:0] insn_t;
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] regIdx_t;
	typedef logic [$clog2(`RV_MEM_CREDITS+1)-1:0] credit_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_SEQ,
		ALU_SNE,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} aluOp_t;

	// encoding is funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DOUBLE} memSize_t;

	typedef enum logic [2:0] {FETCH, WAITI, EXEC, MEMREQ, WAITD} seqState_t;

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1111111, // non-standard
		OP_JALR   = 7'b1110111, // non-standard
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111
	} opcode_t;

endpackage

// File: logic/rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder (
	input  rvPkg::insn_t    insn,
	output rvPkg::regIdx_t  rs1,
	output rvPkg::regIdx_t  rs2,
	output rvPkg::regIdx_t  rd,
	output rvPkg::aluOp_t   aluOp,
	output logic            useImm,
	output logic            usePc,
	output logic            useZero,
	output rvPkg::xlen_t    imm,
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output rvPkg::memSize_t memSize,
	output logic            loadUnsigned,
	output logic            isBranch,
	output logic            isJump,
	output logic            isJalr,
	output logic [2:0]      branchFunct
);
	import rvPkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t immI;
	xlen_t immS;
	xlen_t immU;

	assign opcode = opcode_t'(insn[6:0]);
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	assign rs1 = insn[19:15];
	assign rs2 = insn[24:20];
	assign rd = insn[11:7];
	assign branchFunct = funct3;

	assign immI = {{52{insn[31]}}, insn[31:20]};
	assign immS = {{52{insn[31]}}, insn[31:25], insn[11:7]};
	assign immU = {{32{insn[31]}}, insn[31:12], 12'd0};

	always_comb begin
		aluOp = ALU_ADD;
		useImm = 1'b0;
		usePc = 1'b0;
		useZero = 1'b0;
		imm = '0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = memSize_t'(funct3[1:0]);
		loadUnsigned = funct3[2];
		isBranch = 1'b0;
		isJump = 1'b0;
		isJalr = 1'b0;
		case (opcode)
			OP_R: begin
				regWrite = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: aluOp = ALU_ADD;
					{7'b0110000, 3'b000}: aluOp = ALU_SUB; // odd funct7, kept as is
					{7'b0000000, 3'b001}: aluOp = ALU_SLL;
					{7'b0000000, 3'b010}: aluOp = ALU_SLT;
					{7'b0000001, 3'b010}: aluOp = ALU_SEQ;
					{7'b0000010, 3'b010}: aluOp = ALU_SNE;
					{7'b0000000, 3'b011}: aluOp = ALU_SLTU;
					{7'b0000000, 3'b100}: aluOp = ALU_XOR;
					{7'b0000000, 3'b101}: aluOp = ALU_SRL;
					{7'b0100000, 3'b101}: aluOp = ALU_SRA;
					{7'b0000000, 3'b110}: aluOp = ALU_OR;
					{7'b0000000, 3'b111}: aluOp = ALU_AND;
					default: regWrite = 1'b0;
				endcase
			end
			OP_IMM: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				imm = immI;
				case (funct3)
					3'b000: aluOp = ALU_ADD;
					3'b001: begin
						aluOp = ALU_SLL;
						regWrite = insn[31:26] == 6'b000000;
					end
					3'b010: aluOp = ALU_SLT;
					3'b011: aluOp = ALU_SLTU;
					3'b100: aluOp = ALU_XOR;
					3'b101: begin
						aluOp = insn[30] ? ALU_SRA : ALU_SRL;
						regWrite = {insn[31], insn[29:26]} == 5'b00000; // 6-bit shamt
					end
					3'b110: aluOp = ALU_OR;
					default: aluOp = ALU_AND;
				endcase
			end
			OP_LOAD: begin
				useImm = 1'b1;
				imm = immI;
				memRead = !(funct3[2] && funct3[1]);
				regWrite = memRead;
			end
			OP_STORE: begin
				useImm = 1'b1;
				imm = immS;
				memWrite = !funct3[2];
			end
			OP_BRANCH: begin
				imm = immS << 1;
				isBranch = funct3[2:1] != 2'b01;
			end
			OP_JAL, OP_JALR: begin
				regWrite = 1'b1;
				usePc = 1'b1;
				useImm = 1'b1;
				imm = 64'd4; // link value
				isJump = 1'b1;
				isJalr = opcode == OP_JALR;
			end
			OP_LUI: begin
				regWrite = 1'b1;
				useZero = 1'b1;
				useImm = 1'b1;
				imm = immU;
			end
			OP_AUIPC: begin
				regWrite = 1'b1;
				usePc = 1'b1;
				useImm = 1'b1;
				imm = immU;
			end
			default: ;
		endcase
	end

endmodule

// File: logic/rvAlu.sv
`timescale 1ns/1ps

module rvAlu (
	input  rvPkg::xlen_t  operandA,
	input  rvPkg::xlen_t  operandB,
	input  rvPkg::aluOp_t aluOp,
	input  logic [2:0]    branchFunct,
	output rvPkg::xlen_t  result,
	output logic          branchTaken
);
	import rvPkg::*;

	logic [5:0] shamt;
	logic equal;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = operandB[5:0];
	assign equal = operandA == operandB;
	assign lessSigned = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		case (aluOp)
			ALU_SUB:  result = operandA - operandB;
			ALU_SLL:  result = operandA << shamt;
			ALU_SLT:  result = xlen_t'(lessSigned);
			ALU_SLTU: result = xlen_t'(lessUnsigned);
			ALU_SEQ:  result = xlen_t'(equal);
			ALU_SNE:  result = xlen_t'(!equal);
			ALU_XOR:  result = operandA ^ operandB;
			ALU_SRL:  result = operandA >> shamt;
			ALU_SRA:  result = $signed(operandA) >>> shamt;
			ALU_OR:   result = operandA | operandB;
			ALU_AND:  result = operandA & operandB;
			default:  result = operandA + operandB;
		endcase
	end

	always_comb begin
		case (branchFunct)
			3'b000:  branchTaken = equal;
			3'b001:  branchTaken = !equal;
			3'b100:  branchTaken = lessSigned;
			3'b101:  branchTaken = !lessSigned;
			3'b110:  branchTaken = lessUnsigned;
			3'b111:  branchTaken = !lessUnsigned;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: logic/rvRegFile.sv
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvRegFile (
	input  logic           clk,
	input  logic           rst,
	input  rvPkg::regIdx_t rs1,
	input  rvPkg::regIdx_t rs2,
	input  logic           regWe,
	input  rvPkg::regIdx_t rd,
	input  rvPkg::xlen_t   rdData,
	output rvPkg::xlen_t   rs1Data,
	output rvPkg::xlen_t   rs2Data
);
	import rvPkg::*;

	xlen_t regs [1:`RV_REG_COUNT-1]; // no storage for x0

	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

	// only the stack pointer comes out of reset with a value
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			regs[2] <= `RV_STACK_TOP;
		end else if (regWe && rd != '0) begin
			regs[rd] <= rdData;
		end
	end

endmodule

// File: logic/rvSequencer.sv
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvSequencer (
	input  logic            clk,
	input  logic            rst,
	output rvPkg::insn_t    insn,
	output rvPkg::xlen_t    pc,
	input  logic            useImm,
	input  logic            usePc,
	input  logic            useZero,
	input  rvPkg::xlen_t    imm,
	input  logic            regWrite,
	input  logic            memRead,
	input  logic            memWrite,
	input  rvPkg::memSize_t accessSize,
	input  logic            loadUnsigned,
	input  logic            isBranch,
	input  logic            isJump,
	input  logic            isJalr,
	input  rvPkg::xlen_t    rs1Data,
	input  rvPkg::xlen_t    rs2Data,
	input  rvPkg::xlen_t    aluResult,
	input  logic            branchTaken,
	output rvPkg::xlen_t    operandA,
	output rvPkg::xlen_t    operandB,
	output logic            regWe,
	output rvPkg::xlen_t    rdData,
	output logic            memReq,
	output logic            memWe,
	output rvPkg::xlen_t    memAddr,
	output rvPkg::xlen_t    memWdata,
	output rvPkg::memSize_t memSize,
	input  logic            memCredit,
	input  logic            memRspValid,
	input  rvPkg::xlen_t    memRdata
);
	import rvPkg::*;

	seqState_t state;
	credit_t credits;
	logic hasCredit;
	logic signExt;
	xlen_t pcPlus4;
	xlen_t jalOffset;
	xlen_t jalrTarget;
	xlen_t nextPc;
	xlen_t loadData;

	assign hasCredit = credits != '0;

	// port is shared, so fetch and data access never overlap
	assign memReq = (state == FETCH || state == MEMREQ) && hasCredit;
	assign memWe = state == MEMREQ && memWrite;
	assign memAddr = (state == FETCH) ? pc : aluResult;
	assign memSize = (state == FETCH) ? MEM_WORD : accessSize;
	assign memWdata = rs2Data;

	assign operandA = useZero ? '0 : (usePc ? pc : rs1Data);
	assign operandB = useImm ? imm : rs2Data;

	// decoder imm holds the link constant on jumps, offsets come from insn
	assign pcPlus4 = pc + 64'd4;
	assign jalOffset = {{43{insn[31]}}, insn[31:12], 1'b0};
	assign jalrTarget = (rs1Data + {{52{insn[31]}}, insn[31:20]}) & ~64'd1;

	always_comb begin
		if (isJalr)
			nextPc = jalrTarget;
		else if (isJump)
			nextPc = pc + jalOffset;
		else if (isBranch && branchTaken)
			nextPc = pc + imm; // already shifted
		else
			nextPc = pcPlus4;
	end

	assign signExt = !loadUnsigned;

	always_comb begin
		case (accessSize)
			MEM_BYTE: loadData = {{56{signExt & memRdata[7]}}, memRdata[7:0]};
			MEM_HALF: loadData = {{48{signExt & memRdata[15]}}, memRdata[15:0]};
			MEM_WORD: loadData = {{32{signExt & memRdata[31]}}, memRdata[31:0]};
			default:  loadData = memRdata;
		endcase
	end

	assign regWe = (state == EXEC && regWrite && !memRead) || (state == WAITD && memRspValid);
	assign rdData = (state == WAITD) ? loadData : aluResult;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
			pc <= `RV_RESET_PC;
			credits <= '0;
		end else begin
			credits <= credits + credit_t'(memCredit) - credit_t'(memReq);
			case (state)
				FETCH: if (hasCredit) state <= WAITI;
				WAITI: if (memRspValid) state <= EXEC;
				EXEC: begin
					if (memRead || memWrite) begin
						state <= MEMREQ;
					end else begin
						pc <= nextPc;
						state <= FETCH;
					end
				end
				MEMREQ: begin
					if (hasCredit) begin
						state <= memWrite ? FETCH : WAITD; // stores get no response
						if (memWrite)
							pc <= pcPlus4;
					end
				end
				WAITD: begin
					if (memRspValid) begin
						pc <= pcPlus4;
						state <= FETCH;
					end
				end
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAITI && memRspValid)
			insn <= memRdata[`RV_INSN_W-1:0];
	end

endmodule

// File: logic/rvCore.sv
`timescale 1ns/1ps

module rvCore (
	input  logic            clk,
	input  logic            rst,
	output logic            memReq,
	output logic            memWe,
	output rvPkg::xlen_t    memAddr,
	output rvPkg::xlen_t    memWdata,
	output rvPkg::memSize_t memSize,
	input  logic            memCredit,
	input  logic            memRspValid,
	input  rvPkg::xlen_t    memRdata
);
	import rvPkg::*;

	insn_t insn;
	regIdx_t rs1;
	regIdx_t rs2;
	regIdx_t rd;
	aluOp_t aluOp;
	logic useImm;
	logic usePc;
	logic useZero;
	xlen_t imm;
	logic regWrite;
	logic memRead;
	logic memWrite;
	memSize_t accessSize;
	logic loadUnsigned;
	logic isBranch;
	logic isJump;
	logic isJalr;
	logic [2:0] branchFunct;
	xlen_t rs1Data;
	xlen_t rs2Data;
	xlen_t operandA;
	xlen_t operandB;
	xlen_t aluResult;
	logic branchTaken;
	logic regWe;
	xlen_t rdData;

	rvDecoder uDecoder (
		.insn, .rs1, .rs2, .rd, .aluOp, .useImm, .usePc, .useZero, .imm,
		.regWrite, .memRead, .memWrite, .memSize(accessSize), .loadUnsigned,
		.isBranch, .isJump, .isJalr, .branchFunct
	);

	rvAlu uAlu (
		.operandA, .operandB, .aluOp, .branchFunct,
		.result(aluResult), .branchTaken
	);

	rvRegFile uRegFile (
		.clk, .rst, .rs1, .rs2, .regWe, .rd, .rdData, .rs1Data, .rs2Data
	);

	rvSequencer uSequencer (
		.clk, .rst, .insn, .pc(), .useImm, .usePc, .useZero, .imm,
		.regWrite, .memRead, .memWrite, .accessSize, .loadUnsigned,
		.isBranch, .isJump, .isJalr, .rs1Data, .rs2Data, .aluResult, .branchTaken,
		.operandA, .operandB, .regWe, .rdData,
		.memReq, .memWe, .memAddr, .memWdata, .memSize,
		.memCredit, .memRspValid, .memRdata
	);

endmodule

// File: sim/rvCore_properties.sv
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCoreProperties (
	input logic           clk,
	input logic           rst,
	input logic           memReq,
	input logic           memWe,
	input logic           memCredit,
	input rvPkg::credit_t credits
);
	import rvPkg::*;

	int portCredits; // credits seen on the port less requests

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			portCredits <= 0;
		else
			portCredits <= portCredits + int'(memCredit) - int'(memReq);
	end

	// reset holds the credit count at zero
	noReqInReset: assert property (@(posedge clk) rst |-> !memReq)
		else $error("memReq high during reset");

	// a read waits for its response, so the next cycle is always idle
	singleCycleReq: assert property (@(posedge clk) disable iff (rst)
		memReq && !memWe |=> !memReq)
		else $error("memReq held longer than one cycle");

	reqNeedsCredit: assert property (@(posedge clk) disable iff (rst)
		memReq |-> portCredits > 0)
		else $error("memReq without a credit");

	creditLimit: assert property (@(posedge clk) disable iff (rst)
		credits <= `RV_MEM_CREDITS)
		else $error("credit count above limit");

endmodule

// credit counter lives in the sequencer
bind rvSequencer rvCoreProperties uProps (
	.clk, .rst, .memReq, .memWe, .memCredit, .credits
);

// File: sim/rvCore_tb.sv
`timescale 1ns/1ps
`include "rvCore_settings.svh"

module rvCore_tb;
	import rvPkg::*;

	logic clk;
	logic rst;
	logic memReq;
	logic memWe;
	xlen_t memAddr;
	xlen_t memWdata;
	memSize_t memSize;
	logic memCredit;
	logic memRspValid;
	xlen_t memRdata;

	logic [7:0] mem [0:4095];
	logic [31:0] rngState;
	logic expWe [$];
	xlen_t expAddr [$];
	logic [1:0] expSize [$];
	xlen_t expData [$];
	string expName [$];
	xlen_t progPc;
	int insnCount;
	int storeOff;
	int held;
	int rspCount;
	xlen_t rspData;
	logic withhold;
	logic done;
	logic built;
	xlen_t valA;
	xlen_t valB;
	xlen_t valC;

	string opNames [12] = '{"add", "sub", "sll", "slt", "sltu", "seq", "sne", "xor",
		"srl", "sra", "or", "and"};

	rvCore u_rvCore (
		.clk, .rst, .memReq, .memWe, .memAddr, .memWdata, .memSize,
		.memCredit, .memRspValid, .memRdata
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic xlen_t rand64();
		xlen_t v;
		v[63:32] = xorshift();
		v[31:0] = xorshift();
		return v;
	endfunction

	function automatic xlen_t sizeMask(logic [1:0] size);
		case (size)
			2'd0: return 64'hff;
			2'd1: return 64'hffff;
			2'd2: return 64'hffff_ffff;
			default: return '1;
		endcase
	endfunction

	function automatic xlen_t readMem(xlen_t addr, logic [1:0] size);
		xlen_t v;
		for (int i = 0; i < 8; i++)
			v[8*i +: 8] = mem[12'(addr + i)];
		return v & sizeMask(size);
	endfunction

	task automatic writeBytes(xlen_t addr, xlen_t data, int nBytes);
		for (int i = 0; i < nBytes; i++)
			mem[12'(addr + i)] = data[8*i +: 8];
	endtask

	// reference results straight from the ISA rules
	function automatic xlen_t aluRef(int k, xlen_t a, xlen_t b);
		case (k)
			0: return a + b;
			1: return a - b;
			2: return a << b[5:0];
			3: return xlen_t'($signed(a) < $signed(b));
			4: return xlen_t'(a < b);
			5: return xlen_t'(a == b);
			6: return xlen_t'(a != b);
			7: return a ^ b;
			8: return a >> b[5:0];
			9: return xlen_t'($signed(a) >>> b[5:0]);
			10: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [9:0] rFunct(int k); // {funct7, funct3}
		case (k)
			0: return {7'b0000000, 3'b000};
			1: return {7'b0110000, 3'b000};
			2: return {7'b0000000, 3'b001};
			3: return {7'b0000000, 3'b010};
			4: return {7'b0000000, 3'b011};
			5: return {7'b0000001, 3'b010};
			6: return {7'b0000010, 3'b010};
			7: return {7'b0000000, 3'b100};
			8: return {7'b0000000, 3'b101};
			9: return {7'b0100000, 3'b101};
			10: return {7'b0000000, 3'b110};
			default: return {7'b0000000, 3'b111};
		endcase
	endfunction

	function automatic logic branchRef(logic [2:0] f3, xlen_t a, xlen_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic xlen_t loadRef(logic [2:0] f3, xlen_t w);
		case (f3)
			3'b000: return {{56{w[7]}}, w[7:0]};
			3'b001: return {{48{w[15]}}, w[15:0]};
			3'b010: return {{32{w[31]}}, w[31:0]};
			3'b100: return {56'd0, w[7:0]};
			default: return {48'd0, w[15:0]};
		endcase
	endfunction

	function automatic insn_t encR(logic [9:0] f, int rs2, int rs1, int rd);
		return {f[9:3], 5'(rs2), 5'(rs1), f[2:0], 5'(rd), OP_R};
	endfunction

	function automatic insn_t encI(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
			logic [6:0] op);
		return {imm, 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic insn_t encS(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3,
			logic [6:0] op);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], op};
	endfunction

	task automatic expectAccess(logic we, xlen_t addr, logic [1:0] size, xlen_t data,
			string name);
		expWe.push_back(we);
		expAddr.push_back(addr);
		expSize.push_back(size);
		expData.push_back(data);
		expName.push_back(name);
	endtask

	// word that is skipped over
	task automatic place(insn_t w);
		writeBytes(progPc, xlen_t'(w), 4);
		progPc += 4;
	endtask

	// word that is fetched
	task automatic emit(insn_t w);
		expectAccess(1'b0, progPc, 2'd2, '0, "fetch");
		insnCount++;
		place(w);
	endtask

	task automatic storeResult(int rs, xlen_t value, string name);
		emit(encS(12'(storeOff), rs, 1, 3'b011, OP_STORE));
		expectAccess(1'b1, 64'h400 + xlen_t'(storeOff), 2'd3, value, name);
		storeOff += 8;
	endtask

	task automatic buildProgram();
		int iOps [9] = '{0, 2, 3, 4, 7, 8, 9, 10, 11};
		int loadF3 [5] = '{0, 1, 2, 4, 5};
		int brF3 [6] = '{0, 1, 4, 5, 6, 7};
		logic [11:0] imm;
		logic [5:0] sh;
		logic [19:0] u;
		xlen_t jalPc;
		xlen_t here;
		int ra;
		int rb;
		insn_t nop;
		nop = encI(12'd0, 0, 3'b000, 0, OP_IMM);
		valA = rand64();
		valB = rand64();
		valC = rand64();
		writeBytes(64'h400, valA, 8);
		writeBytes(64'h408, valB, 8);
		writeBytes(64'h410, valC, 8);
		emit(encI(12'h400, 0, 3'b000, 1, OP_IMM)); // x1 = data base
		emit(encI(12'd0, 1, 3'b011, 5, OP_LOAD));
		expectAccess(1'b0, 64'h400, 2'd3, '0, "ld a");
		emit(encI(12'd8, 1, 3'b011, 6, OP_LOAD));
		expectAccess(1'b0, 64'h408, 2'd3, '0, "ld b");
		for (int k = 0; k < 12; k++) begin
			emit(encR(rFunct(k), 6, 5, 7));
			storeResult(7, aluRef(k, valA, valB), opNames[k]);
		end
		for (int j = 0; j < 9; j++) begin
			sh = 6'(xorshift());
			imm = 12'(xorshift());
			if (iOps[j] == 2 || iOps[j] == 8)
				imm = {6'b000000, sh};
			else if (iOps[j] == 9)
				imm = {6'b010000, sh}; // srai
			emit(encI(imm, 5, 3'(rFunct(iOps[j])), 7, OP_IMM));
			storeResult(7, aluRef(iOps[j], valA, {{52{imm[11]}}, imm}),
				{opNames[iOps[j]], "i"});
		end
		for (int j = 0; j < 5; j++) begin
			emit(encI(12'd16, 1, 3'(loadF3[j]), 7, OP_LOAD));
			expectAccess(1'b0, 64'h410, 2'(loadF3[j]), '0, "load access");
			storeResult(7, loadRef(3'(loadF3[j]), valC), $sformatf("load f3=%0d", loadF3[j]));
		end
		for (int j = 0; j < 3; j++) begin
			emit(encS(12'h300 + 12'(8 * j), 5, 1, 3'(j), OP_STORE));
			expectAccess(1'b1, 64'h700 + xlen_t'(8 * j), 2'(j), valA,
				$sformatf("narrow store %0d", j));
		end
		for (int j = 0; j < 6; j++) begin
			for (int p = 0; p < 3; p++) begin
				ra = (p == 2) ? 6 : 5;
				rb = (p == 1) ? 6 : 5;
				emit(encS(12'd4, rb, ra, 3'(brF3[j]), OP_BRANCH)); // offset 8
				if (branchRef(3'(brF3[j]), ra == 5 ? valA : valB, rb == 5 ? valA : valB))
					place(nop);
				else
					emit(nop);
			end
		end
		jalPc = progPc;
		emit({20'd6, 5'd8, OP_JAL}); // jumps 12 bytes
		place(nop);
		place(nop);
		storeResult(8, jalPc + 4, "jal link");
		here = progPc;
		emit(encI(12'(here + 8 - (jalPc + 4)), 8, 3'b000, 9, OP_JALR));
		place(nop);
		storeResult(9, here + 4, "jalr link");
		u = 20'(xorshift());
		emit({u, 5'd10, OP_LUI});
		storeResult(10, {{32{u[19]}}, u, 12'd0}, "lui");
		u = 20'(xorshift());
		here = progPc;
		emit({u, 5'd11, OP_AUIPC});
		storeResult(11, here + {{32{u[19]}}, u, 12'd0}, "auipc");
	endtask

	task automatic mismatch(string name, xlen_t expected, xlen_t actual);
		$display("FAIL %s expected %h actual %h", name, expected, actual);
		$display("Verification failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic failWith(string text);
		$display("%s", text);
		$display("Verification failed");
		$fatal(1, "check failed");
	endtask

	task automatic checkAccess();
		logic we;
		xlen_t addr;
		logic [1:0] size;
		xlen_t data;
		string name;
		assert (expName.size() > 0) else failWith("memory request after the end of the program");
		we = expWe.pop_front();
		addr = expAddr.pop_front();
		size = expSize.pop_front();
		data = expData.pop_front();
		name = expName.pop_front();
		assert (memWe == we) else mismatch({name, " we"}, xlen_t'(we), xlen_t'(memWe));
		assert (memAddr == addr) else mismatch({name, " addr"}, addr, memAddr);
		assert (memSize == size) else mismatch({name, " size"}, xlen_t'(size), xlen_t'(memSize));
		if (we) begin
			assert ((memWdata & sizeMask(size)) == (data & sizeMask(size)))
				else mismatch({name, " data"}, data & sizeMask(size), memWdata & sizeMask(size));
			writeBytes(memAddr, memWdata, 1 << size);
		end else begin
			rspData = readMem(memAddr, memSize);
			rspCount = 1 + xorshift() % 4;
		end
		if (expName.size() == 0)
			done = 1'b1;
	endtask

	// outputs are sampled mid-cycle, where they are settled
	always @(negedge clk) begin
		if (!rst && !done) begin
			held = held + int'(memCredit) - int'(memReq);
			assert (!(withhold && memReq))
				else failWith("request issued while credits were withheld");
			if (memReq)
				checkAccess();
		end
	end

	always @(posedge clk) begin
		#1;
		memRspValid = 1'b0;
		if (rspCount > 0) begin
			rspCount--;
			if (rspCount == 0) begin
				memRspValid = 1'b1;
				memRdata = rspData;
			end
		end
		memCredit = !rst && !withhold && held < `RV_MEM_CREDITS && (xorshift() % 4 != 0);
	end

	initial begin
		wait (built);
		repeat (200 * insnCount) @(posedge clk);
		$display("watchdog expired before the program finished");
		$display("Verification failed");
		$fatal(1, "timeout");
	end

	initial begin
		rst = 1'b1;
		memCredit = 1'b0;
		memRspValid = 1'b0;
		memRdata = '0;
		rngState = 32'h0609_7004;
		withhold = 1'b1;
		done = 1'b0;
		built = 1'b0;
		held = 0;
		rspCount = 0;
		rspData = '0;
		insnCount = 0;
		storeOff = 'h100;
		progPc = `RV_RESET_PC;
		for (int i = 0; i < 4096; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8);
		buildProgram();
		built = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		repeat (8) @(posedge clk);
		withhold = 1'b0;
		wait (done);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/rvPkg.sv
logic/rvDecoder.sv
logic/rvAlu.sv
logic/rvRegFile.sv
logic/rvSequencer.sv
logic/rvCore.sv
sim/rvCore_properties.sv
sim/rvCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= rvCore_tb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
